// File: bench/router_tests.svh
`ifndef ROUTER_TESTS_SVH
`define ROUTER_TESTS_SVH

    // nothing driven, so any strobe is flagged by the monitor
    task automatic idle_after_reset();
        begin_test("idle");
        repeat (20) next_cycle();
        end_test();
    endtask

    // local destination leaves on the eject port of the arrival link
    task automatic eject_local();
        begin_test("eject");
        for (int i = 0; i < 2; i++) begin
            send_link(0, make_flit(node_x, node_y, 0));
            send_link(1, make_flit(node_x, node_y, 1));
            next_cycle();
        end
        wait_drain();
        end_test();
    endtask

    // x mismatch goes +x, x match with y mismatch goes +y
    task automatic route_by_dimension();
        begin_test("routing");
        for (int i = 0; i < 6; i++) begin
            if (i % 2 == 0) begin
                send_link(0, make_flit(other_coord(node_x), rand_coord(), 0));
                send_link(1, make_flit(node_x, other_coord(node_y), 1));
            end else begin
                send_link(0, make_flit(node_x, other_coord(node_y), 0));
                send_link(1, make_flit(other_coord(node_x), rand_coord(), 1));
            end
            next_cycle();
        end
        wait_drain();
        end_test();
    endtask

    // both inputs fight for +x, round robin must lose nothing
    task automatic contend_for_xpos();
        begin_test("contention");
        for (int i = 0; i < 4; i++) begin
            send_link(0, make_flit(other_coord(node_x), rand_coord(), 0));
            send_link(1, make_flit(other_coord(node_x), rand_coord(), 1));
            next_cycle();
        end
        wait_drain();
        end_test();
    endtask

    // injection preempts the transit stream on +x every other cycle
    task automatic inject_over_transit();
        begin_test("injection");
        for (int i = 0; i < 8; i++) begin
            if (i < 6) begin
                send_link(0, make_flit(other_coord(node_x), rand_coord(), 0));
            end
            if (i % 2 == 0) begin
                send_inject(0, make_flit(rand_coord(), rand_coord(), 2));
            end
            next_cycle();
        end
        wait_drain();
        end_test();
    endtask

    // random destinations biased toward this node, at most 4 in flight per link
    task automatic random_mix();
        int link_sent [2];
        int inj_sent [2];
        router_pkg::coord_t dx;
        router_pkg::coord_t dy;
        link_sent = '{0, 0};
        inj_sent  = '{0, 0};
        begin_test("random");
        while (link_sent[0] < 24 || link_sent[1] < 24) begin
            for (int l = 0; l < 2; l++) begin
                if (link_sent[l] < 24 && outstanding[l] < 4 && $urandom % 2 == 0) begin
                    dx = ($urandom % 3 == 0) ? node_x : rand_coord();
                    dy = ($urandom % 3 == 0) ? node_y : rand_coord();
                    send_link(l, make_flit(dx, dy, l));
                    link_sent[l]++;
                end
                // sparse injection so the switch is never starved for long
                if (inj_sent[l] < 8 && $urandom % 8 == 0) begin
                    send_inject(l, make_flit(rand_coord(), rand_coord(), 2));
                    inj_sent[l]++;
                end
            end
            next_cycle();
        end
        wait_drain();
        end_test();
    endtask

`endif

// File: bench/router_tb.sv
`timescale 1ns/10ps
`include "router_macros.svh"

module router_tb;

    localparam router_pkg::coord_t node_x = 3'd2;
    localparam router_pkg::coord_t node_y = 3'd5;
    // source tag sits in the top two payload bits and 2 marks an injected flit
    localparam int tag_lsb = `ROUTER_PAYLOAD_W - 2;
    // eject 4, routing 12, contention 8, injection 10, random 48 plus 16 injected
    localparam int total_flits = 98;

    logic              clk;
    logic              rst;
    router_pkg::flit_t in_xpos;
    logic              in_xpos_valid;
    router_pkg::flit_t in_ypos;
    logic              in_ypos_valid;
    router_pkg::flit_t inject_xpos;
    logic              inject_xpos_valid;
    router_pkg::flit_t inject_ypos;
    logic              inject_ypos_valid;
    router_pkg::flit_t out_xpos;
    logic              out_xpos_valid;
    router_pkg::flit_t out_ypos;
    logic              out_ypos_valid;
    router_pkg::flit_t eject_xpos;
    logic              eject_xpos_valid;
    router_pkg::flit_t eject_ypos;
    logic              eject_ypos_valid;

    // expected flits indexed by output * 3 + source
    // output 0 is out_xpos, 1 out_ypos, 2 eject_xpos and 3 eject_ypos
    router_pkg::flit_t exp_q [12][$];
    int                outstanding [2];
    int                err_count;
    int                check_total;
    int                sent_count;
    int                recv_count;
    int                test_sent;
    int                test_recv;
    int                test_err0;
    string             test_name;

    router #(
        .cur_x(node_x),
        .cur_y(node_y)
    ) DUT (
        .clk               (clk),
        .rst               (rst),
        .in_xpos           (in_xpos),
        .in_xpos_valid     (in_xpos_valid),
        .in_ypos           (in_ypos),
        .in_ypos_valid     (in_ypos_valid),
        .inject_xpos       (inject_xpos),
        .inject_xpos_valid (inject_xpos_valid),
        .inject_ypos       (inject_ypos),
        .inject_ypos_valid (inject_ypos_valid),
        .out_xpos          (out_xpos),
        .out_xpos_valid    (out_xpos_valid),
        .out_ypos          (out_ypos),
        .out_ypos_valid    (out_ypos_valid),
        .eject_xpos        (eject_xpos),
        .eject_xpos_valid  (eject_xpos_valid),
        .eject_ypos        (eject_ypos),
        .eject_ypos_valid  (eject_ypos_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_flit(router_pkg::flit_t got, router_pkg::flit_t exp, string what);
        check_total++;
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        check_total++;
        if (got != exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    // match an output flit against the queue of the source named in its tag
    task automatic take_flit(int port, router_pkg::flit_t got, string name);
        int src;
        int idx;
        src = int'(got[tag_lsb +: 2]);
        idx = port * 3 + src;
        if (src > 2 || exp_q[idx].size() == 0) begin
            $display("unexpected flit %h on %s at time %0t", got, name, $time);
            err_count++;
        end else begin
            check_flit(got, exp_q[idx].pop_front(), name);
            recv_count++;
            test_recv++;
            if (src < 2) begin
                outstanding[src]--;
            end
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!rst) begin
            if (out_xpos_valid) begin
                take_flit(0, out_xpos, "out_xpos");
            end
            if (out_ypos_valid) begin
                take_flit(1, out_ypos, "out_ypos");
            end
            if (eject_xpos_valid) begin
                take_flit(2, eject_xpos, "eject_xpos");
            end
            if (eject_ypos_valid) begin
                take_flit(3, eject_ypos, "eject_ypos");
            end
        end
    end

    function automatic router_pkg::coord_t rand_coord();
        return router_pkg::coord_t'($urandom % 8);
    endfunction

    // any coordinate except c
    function automatic router_pkg::coord_t other_coord(router_pkg::coord_t c);
        return router_pkg::coord_t'((int'(c) + 1 + int'($urandom % 7)) % 8);
    endfunction

    function automatic router_pkg::flit_t make_flit(router_pkg::coord_t dx,
                                                    router_pkg::coord_t dy, int src);
        router_pkg::flit_t f;
        f = '0;
        f[31:0] = $urandom;
        f[63:32] = $urandom;
        f[tag_lsb +: 2] = 2'(src);
        f[`ROUTER_DST_X_LSB +: `ROUTER_COORD_W] = dx;
        f[`ROUTER_DST_Y_LSB +: `ROUTER_COORD_W] = dy;
        f[`ROUTER_DST_Z_LSB +: `ROUTER_COORD_W] = rand_coord();
        return f;
    endfunction

    // dimension order ejects a local flit on its arrival link, then tries x, then y
    function automatic int predict_port(int link, router_pkg::flit_t f);
        router_pkg::coord_t dx;
        router_pkg::coord_t dy;
        dx = f[`ROUTER_DST_X_LSB +: `ROUTER_COORD_W];
        dy = f[`ROUTER_DST_Y_LSB +: `ROUTER_COORD_W];
        if (dx == node_x && dy == node_y) begin
            return 2 + link;
        end else if (dx != node_x) begin
            return 0;
        end
        return 1;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int i = 0; i < 12; i++) begin
            n += exp_q[i].size();
        end
        return n;
    endfunction

    // strobes last one cycle, drives follow each falling edge
    task automatic next_cycle();
        @(negedge clk);
        in_xpos_valid     = 1'b0;
        in_ypos_valid     = 1'b0;
        inject_xpos_valid = 1'b0;
        inject_ypos_valid = 1'b0;
    endtask

    task automatic send_link(int link, router_pkg::flit_t f);
        exp_q[predict_port(link, f) * 3 + link].push_back(f);
        outstanding[link]++;
        sent_count++;
        test_sent++;
        if (link == 0) begin
            in_xpos       = f;
            in_xpos_valid = 1'b1;
        end else begin
            in_ypos       = f;
            in_ypos_valid = 1'b1;
        end
    endtask

    // injected flits bypass routing and leave on their own port
    task automatic send_inject(int port, router_pkg::flit_t f);
        exp_q[port * 3 + 2].push_back(f);
        sent_count++;
        test_sent++;
        if (port == 0) begin
            inject_xpos       = f;
            inject_xpos_valid = 1'b1;
        end else begin
            inject_ypos       = f;
            inject_ypos_valid = 1'b1;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (pending() != 0 && n < 400) begin
            next_cycle();
            n++;
        end
        if (pending() != 0) begin
            $display("%0d flits never arrived in test %s", pending(), test_name);
            err_count++;
        end
        // a few idle cycles to catch stray extra strobes
        repeat (5) next_cycle();
    endtask

    task automatic begin_test(string name);
        test_name = name;
        test_err0 = err_count;
        test_sent = 0;
        test_recv = 0;
    endtask

    task automatic end_test();
        check_count(test_recv, test_sent, {test_name, " flits received"});
        $display("test %s: %s, %0d flits sent, %0d received", test_name,
                 (err_count == test_err0) ? "ok" : "FAILED", test_sent, test_recv);
    endtask

`include "router_tests.svh"

    // run length bound scales with the traffic sent by all tests
    initial begin
        repeat (total_flits * 40 + 200) @(posedge clk);
        $display("watchdog expired with %0d flits outstanding", pending());
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        void'($urandom(32'h6def));
        rst               = 1'b1;
        in_xpos           = '0;
        in_xpos_valid     = 1'b0;
        in_ypos           = '0;
        in_ypos_valid     = 1'b0;
        inject_xpos       = '0;
        inject_xpos_valid = 1'b0;
        inject_ypos       = '0;
        inject_ypos_valid = 1'b0;
        outstanding[0]    = 0;
        outstanding[1]    = 0;
        err_count         = 0;
        check_total       = 0;
        sent_count        = 0;
        recv_count        = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idle_after_reset();
        eject_local();
        route_by_dimension();
        contend_for_xpos();
        inject_over_transit();
        random_mix();
        $display("summary: %0d checks, %0d errors, %0d flits sent, %0d received",
                 check_total, err_count, sent_count, recv_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+rtl
+incdir+bench
rtl/router_pkg.sv
rtl/flit_queue.sv
rtl/route_comp.sv
rtl/input_port.sv
rtl/switch_alloc.sv
rtl/router.sv
bench/router_tb.sv

// File: rtl/flit_queue.sv
`timescale 1ns/10ps

module flit_queue #(
    parameter int width = 81,
    parameter int depth = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [width-1:0] wr_data,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [width-1:0] rd_data,
    output logic             not_empty,
    output logic             full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    // entry storage
    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // wrap at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            next_ptr = '0;
        end else begin
            next_ptr = ptr + 1'b1;
        end
    endfunction

    assign full      = (count == cnt_w'(depth));
    assign not_empty = (count != '0);

    // overflow writes and underflow pops are dropped here
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && not_empty;

    // show-ahead head is visible without a pop
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // occupancy only moves when exactly one side fires
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rtl/input_port.sv
`timescale 1ns/10ps
`include "router_macros.svh"

module input_port #(
    parameter router_pkg::coord_t cur_x = '0,
    parameter router_pkg::coord_t cur_y = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  router_pkg::flit_t        in_flit,
    input  logic                     in_valid,
    output router_pkg::flit_t        eject_flit,
    output logic                     eject_valid,
    output router_pkg::routed_flit_t sw_head,
    output logic                     sw_head_valid,
    input  logic                     sw_grant
);

    localparam int lvl_w = $clog2(`ROUTER_QUEUE_DEPTH + 1);

    router_pkg::flit_t        in_head;
    logic                     in_not_empty;
    logic                     rc_pop;
    router_pkg::routed_flit_t rc_flit;
    logic                     rc_valid;
    logic                     sw_pop;
    logic [lvl_w-1:0]         sw_level;

    // input queue drops overflow since nothing pushes back upstream
    flit_queue #(
        .width(`ROUTER_FLIT_W),
        .depth(`ROUTER_QUEUE_DEPTH)
    ) in_queue (
        .clk       (clk),
        .rst       (rst),
        .wr_data   (in_flit),
        .wr_en     (in_valid),
        .rd_en     (rc_pop),
        .rd_data   (in_head),
        .not_empty (in_not_empty),
        .full      ()
    );

    // stall rule
    // the flit already in the stage owns a slot, so pop only if one more fits
    assign rc_pop = in_not_empty &&
                    ((int'(sw_level) + int'(rc_valid)) < `ROUTER_QUEUE_DEPTH);

    route_comp #(
        .cur_x(cur_x),
        .cur_y(cur_y)
    ) rc (
        .clk         (clk),
        .rst         (rst),
        .in_flit     (in_head),
        .in_valid    (rc_pop),
        .out_flit    (rc_flit),
        .out_valid   (rc_valid),
        .eject_flit  (eject_flit),
        .eject_valid (eject_valid)
    );

    // switch queue entries carry their route code
    flit_queue #(
        .width($bits(router_pkg::routed_flit_t)),
        .depth(`ROUTER_QUEUE_DEPTH)
    ) sw_queue (
        .clk       (clk),
        .rst       (rst),
        .wr_data   (rc_flit),
        .wr_en     (rc_valid),
        .rd_en     (sw_grant),
        .rd_data   (sw_head),
        .not_empty (sw_head_valid),
        .full      ()
    );

    assign sw_pop = sw_grant && sw_head_valid;

    // switch queue occupancy as seen by the stall rule
    always_ff @(posedge clk) begin
        if (rst) begin
            sw_level <= '0;
        end else begin
            case ({rc_valid, sw_pop})
                2'b10:   sw_level <= sw_level + lvl_w'(1);
                2'b01:   sw_level <= sw_level - lvl_w'(1);
                default: sw_level <= sw_level;
            endcase
        end
    end

endmodule

// File: rtl/route_comp.sv
`timescale 1ns/10ps
`include "router_macros.svh"

module route_comp #(
    parameter router_pkg::coord_t cur_x = '0,
    parameter router_pkg::coord_t cur_y = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  router_pkg::flit_t        in_flit,
    input  logic                     in_valid,
    output router_pkg::routed_flit_t out_flit,
    output logic                     out_valid,
    output router_pkg::flit_t        eject_flit,
    output logic                     eject_valid
);

    router_pkg::coord_t     dst_x;
    router_pkg::coord_t     dst_y;
    router_pkg::route_dir_e dir_d;
    router_pkg::route_dir_e dir_q;
    router_pkg::flit_t      flit_q;

    // only the x and y destination fields take part
    assign dst_x = in_flit[`ROUTER_DST_X_LSB +: `ROUTER_COORD_W];
    assign dst_y = in_flit[`ROUTER_DST_Y_LSB +: `ROUTER_COORD_W];

    // dimension order resolves x first and y second
    always_comb begin
        if (dst_x == cur_x && dst_y == cur_y) begin
            dir_d = router_pkg::ROUTE_EJECT;
        end else if (dst_x != cur_x) begin
            dir_d = router_pkg::ROUTE_XPOS;
        end else begin
            dir_d = router_pkg::ROUTE_YPOS;
        end
    end

    // payload register shared by the eject and switch sides
    always_ff @(posedge clk) begin
        if (in_valid) begin
            flit_q <= in_flit;
            dir_q  <= dir_d;
        end
    end

    // strobes say which side the registered flit belongs to
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            eject_valid <= 1'b0;
        end else begin
            out_valid   <= in_valid && (dir_d != router_pkg::ROUTE_EJECT);
            eject_valid <= in_valid && (dir_d == router_pkg::ROUTE_EJECT);
        end
    end

    assign out_flit.dir  = dir_q;
    assign out_flit.flit = flit_q;
    assign eject_flit    = flit_q;

endmodule

// File: rtl/router.sv
`timescale 1ns/10ps

module router #(
    parameter router_pkg::coord_t cur_x = '0,
    parameter router_pkg::coord_t cur_y = '0
) (
    input  logic              clk,
    input  logic              rst,
    // network links in
    input  router_pkg::flit_t in_xpos,
    input  logic              in_xpos_valid,
    input  router_pkg::flit_t in_ypos,
    input  logic              in_ypos_valid,
    // kernel injection
    input  router_pkg::flit_t inject_xpos,
    input  logic              inject_xpos_valid,
    input  router_pkg::flit_t inject_ypos,
    input  logic              inject_ypos_valid,
    // network links out
    output router_pkg::flit_t out_xpos,
    output logic              out_xpos_valid,
    output router_pkg::flit_t out_ypos,
    output logic              out_ypos_valid,
    // kernel ejection, one per arrival link
    output router_pkg::flit_t eject_xpos,
    output logic              eject_xpos_valid,
    output router_pkg::flit_t eject_ypos,
    output logic              eject_ypos_valid
);

    router_pkg::routed_flit_t xpos_head;
    router_pkg::routed_flit_t ypos_head;
    logic                     xpos_head_valid;
    logic                     ypos_head_valid;
    logic                     xpos_grant;
    logic                     ypos_grant;

    input_port #(
        .cur_x(cur_x),
        .cur_y(cur_y)
    ) xpos_in (
        .clk           (clk),
        .rst           (rst),
        .in_flit       (in_xpos),
        .in_valid      (in_xpos_valid),
        .eject_flit    (eject_xpos),
        .eject_valid   (eject_xpos_valid),
        .sw_head       (xpos_head),
        .sw_head_valid (xpos_head_valid),
        .sw_grant      (xpos_grant)
    );

    input_port #(
        .cur_x(cur_x),
        .cur_y(cur_y)
    ) ypos_in (
        .clk           (clk),
        .rst           (rst),
        .in_flit       (in_ypos),
        .in_valid      (in_ypos_valid),
        .eject_flit    (eject_ypos),
        .eject_valid   (eject_ypos_valid),
        .sw_head       (ypos_head),
        .sw_head_valid (ypos_head_valid),
        .sw_grant      (ypos_grant)
    );

    // allocation, crossbar and injection override
    switch_alloc sa (
        .clk               (clk),
        .rst               (rst),
        .xpos_head         (xpos_head),
        .ypos_head         (ypos_head),
        .xpos_head_valid   (xpos_head_valid),
        .ypos_head_valid   (ypos_head_valid),
        .xpos_grant        (xpos_grant),
        .ypos_grant        (ypos_grant),
        .inject_xpos       (inject_xpos),
        .inject_ypos       (inject_ypos),
        .inject_xpos_valid (inject_xpos_valid),
        .inject_ypos_valid (inject_ypos_valid),
        .out_xpos          (out_xpos),
        .out_ypos          (out_ypos),
        .out_xpos_valid    (out_xpos_valid),
        .out_ypos_valid    (out_ypos_valid)
    );

endmodule

// File: rtl/router_macros.svh
`ifndef ROUTER_MACROS_SVH
`define ROUTER_MACROS_SVH

// full flit holds payload then dst x, dst y and dst z from the low end
`define ROUTER_FLIT_W 81

// payload sits in bits 0 to 71
`define ROUTER_PAYLOAD_W 72

// each coordinate is 3 bits, so an 8x8x8 space
`define ROUTER_COORD_W 3

// destination x field low bit
`define ROUTER_DST_X_LSB 72

// destination y field low bit
`define ROUTER_DST_Y_LSB 75

// destination z field low bit
// z is carried through but no z ports exist, so it is never compared
`define ROUTER_DST_Z_LSB 78

// entries in every input and switch queue
`define ROUTER_QUEUE_DEPTH 8

`endif

// File: rtl/router_pkg.sv
`include "router_macros.svh"

package router_pkg;

    // raw flit as it travels on the links
    // [71:0] payload, [74:72] dst x, [77:75] dst y, [80:78] dst z
    typedef logic [`ROUTER_FLIT_W-1:0] flit_t;

    // one mesh coordinate
    typedef logic [`ROUTER_COORD_W-1:0] coord_t;

    // output choice made by route computation
    // eject never reaches a switch queue, the stage strips it off
    typedef enum logic [1:0] {
        ROUTE_XPOS  = 2'd0,
        ROUTE_YPOS  = 2'd1,
        ROUTE_EJECT = 2'd2
    } route_dir_e;

    // switch queue entry
    // the route code rides in the same entry as the flit it belongs to
    typedef struct packed {
        route_dir_e dir;
        flit_t      flit;
    } routed_flit_t;

endpackage

// File: rtl/switch_alloc.sv
`timescale 1ns/10ps

module switch_alloc (
    input  logic                     clk,
    input  logic                     rst,
    input  router_pkg::routed_flit_t xpos_head,
    input  router_pkg::routed_flit_t ypos_head,
    input  logic                     xpos_head_valid,
    input  logic                     ypos_head_valid,
    output logic                     xpos_grant,
    output logic                     ypos_grant,
    input  router_pkg::flit_t        inject_xpos,
    input  router_pkg::flit_t        inject_ypos,
    input  logic                     inject_xpos_valid,
    input  logic                     inject_ypos_valid,
    output router_pkg::flit_t        out_xpos,
    output router_pkg::flit_t        out_ypos,
    output logic                     out_xpos_valid,
    output logic                     out_ypos_valid
);

    // index 0 is the xpos side, 1 the ypos side, for inputs and outputs alike
    router_pkg::flit_t      head_flit [2];
    router_pkg::route_dir_e head_dir [2];
    logic [1:0]             head_valid;
    router_pkg::flit_t      inj_flit [2];
    logic [1:0]             inj_valid;
    // req[o][i] and gnt[o][i] pair input i with output o
    logic [1:0]             req [2];
    logic [1:0]             gnt [2];
    // one bit per output where 0 favors the xpos input on a tie
    logic [1:0]             rr_ptr;
    router_pkg::flit_t      out_flit_q [2];
    logic [1:0]             out_valid_q;

    assign head_flit[0] = xpos_head.flit;
    assign head_flit[1] = ypos_head.flit;
    assign head_dir[0]  = xpos_head.dir;
    assign head_dir[1]  = ypos_head.dir;
    assign head_valid   = {ypos_head_valid, xpos_head_valid};
    assign inj_flit[0]  = inject_xpos;
    assign inj_flit[1]  = inject_ypos;
    assign inj_valid    = {inject_ypos_valid, inject_xpos_valid};

    // requests come from heads whose route names the output
    always_comb begin
        for (int o = 0; o < 2; o++) begin
            for (int i = 0; i < 2; i++) begin
                req[o][i] = head_valid[i] &&
                            (head_dir[i] == ((o == 0) ? router_pkg::ROUTE_XPOS
                                                      : router_pkg::ROUTE_YPOS));
            end
        end
    end

    // injection wins the output outright, otherwise round robin on a tie
    always_comb begin
        for (int o = 0; o < 2; o++) begin
            gnt[o] = 2'b00;
            if (!inj_valid[o]) begin
                if (req[o] == 2'b11) begin
                    gnt[o] = rr_ptr[o] ? 2'b10 : 2'b01;
                end else begin
                    gnt[o] = req[o];
                end
            end
        end
    end

    // one pop per input since a head only ever asks for one output
    assign xpos_grant = gnt[0][0] | gnt[1][0];
    assign ypos_grant = gnt[0][1] | gnt[1][1];

    // crossbar into the output registers
    always_ff @(posedge clk) begin
        for (int o = 0; o < 2; o++) begin
            if (inj_valid[o]) begin
                out_flit_q[o] <= inj_flit[o];
            end else if (gnt[o][1]) begin
                out_flit_q[o] <= head_flit[1];
            end else begin
                out_flit_q[o] <= head_flit[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 2'b00;
            rr_ptr      <= 2'b00;
        end else begin
            for (int o = 0; o < 2; o++) begin
                out_valid_q[o] <= inj_valid[o] | (|gnt[o]);
                // after serving one input, point at the other
                if (|gnt[o]) begin
                    rr_ptr[o] <= gnt[o][0];
                end
            end
        end
    end

    assign out_xpos       = out_flit_q[0];
    assign out_ypos       = out_flit_q[1];
    assign out_xpos_valid = out_valid_q[0];
    assign out_ypos_valid = out_valid_q[1];

endmodule

// File: run.sh
#!/bin/sh
# build and run the router testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/10ps --top-module router_tb \
    -f files.f -o Vrouter_tb \
    && ./obj_dir/Vrouter_tb | tee sim.log \
    && grep -q "^NO ERRORS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
